// File: mem1_pkg.sv
`include "mem1_settings.svh"

package mem1_pkg;

    // Data word and physical address
    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`OP_W-1:0] aluop_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Privilege level where 3 is user
    typedef logic [1:0] plv_t;

    // One enable per byte lane
    typedef logic [3:0] byte_sel_t;

    // 0 byte, 1 half, 2 word
    typedef logic [2:0] access_type_t;

    // {pil, pis, ppi, pme, tlbr, adem}
    typedef logic [5:0] excp_vec_t;

endpackage

// File: mem1_result_merge.sv
module mem1_result_merge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,
    input  logic                   advance_i,
    input  logic                   instr_valid_i,
    input  logic                   mem_load_i,
    input  logic                   mem_store_i,
    input  logic                   excp_i,
    input  mem1_pkg::excp_vec_t    excp_vec_i,
    input  logic                   wreg_i,
    input  mem1_pkg::reg_addr_t    waddr_i,
    input  mem1_pkg::word_t        wdata_i,
    input  mem1_pkg::word_t        paddr_i,
    input  mem1_pkg::aluop_t       aluop_i,
    input  logic                   enc_ce_i,
    input  logic                   enc_we_i,
    input  mem1_pkg::byte_sel_t    enc_sel_i,
    input  mem1_pkg::word_t        enc_wdata_i,
    input  mem1_pkg::access_type_t enc_rd_type_i,
    input  mem1_pkg::access_type_t enc_wr_type_i,
    input  logic                   atom_ll_i,
    input  logic                   atom_sc_i,
    input  logic                   atom_sc_ok_i,
    input  logic                   dcache_ready_i,
    input  logic                   dcache_ack_i,
    output logic                   dcache_ce_o,
    output logic                   dcache_we_o,
    output mem1_pkg::byte_sel_t    dcache_sel_o,
    output mem1_pkg::word_t        dcache_addr_o,
    output mem1_pkg::word_t        dcache_wdata_o,
    output mem1_pkg::access_type_t dcache_rd_type_o,
    output mem1_pkg::access_type_t dcache_wr_type_o,
    output logic                   advance_ready_o,
    output logic                   fwd_wreg_o,
    output logic                   fwd_final_o,
    output mem1_pkg::reg_addr_t    fwd_waddr_o,
    output mem1_pkg::word_t        fwd_wdata_o,
    output logic                   stage_valid_o,
    output logic                   stage_excp_o,
    output mem1_pkg::excp_vec_t    stage_excp_vec_o,
    output logic                   stage_wreg_o,
    output mem1_pkg::reg_addr_t    stage_waddr_o,
    output mem1_pkg::word_t        stage_wdata_o,
    output logic                   stage_llbit_we_o,
    output logic                   stage_llbit_value_o,
    output mem1_pkg::word_t        stage_addr_o,
    output mem1_pkg::aluop_t       stage_aluop_o,
    output logic                   stage_access_o
);

    import mem1_pkg::*;

    logic  mem_access_valid;
    logic  access_mem;
    logic  send_req;
    logic  sc_valid;
    logic  next_wreg;
    word_t next_wdata;
    logic  next_llbit_we;
    logic  next_llbit_value;

    assign mem_access_valid = instr_valid_i & ~excp_i;
    assign access_mem       = mem_load_i | mem_store_i;
    assign send_req         = mem_access_valid & dcache_ready_i & enc_ce_i;

    // Request fields are zero whenever nothing is sent
    assign dcache_ce_o      = send_req;
    assign dcache_we_o      = send_req & enc_we_i;
    assign dcache_sel_o     = send_req ? enc_sel_i : '0;
    assign dcache_addr_o    = send_req ? paddr_i : '0;
    assign dcache_wdata_o   = send_req ? enc_wdata_i : '0;
    assign dcache_rd_type_o = send_req ? enc_rd_type_i : '0;
    assign dcache_wr_type_o = send_req ? enc_wr_type_i : '0;

    // Hold the pipe until the cache acknowledges
    assign advance_ready_o = ~(access_mem & mem_access_valid & ~dcache_ack_i);

    // SC returns its success flag in the destination register
    assign sc_valid         = mem_access_valid & atom_sc_i;
    assign next_wreg        = sc_valid ? 1'b1 : wreg_i;
    assign next_wdata       = sc_valid ? word_t'(atom_sc_ok_i) : wdata_i;
    assign next_llbit_we    = mem_access_valid & (atom_ll_i | atom_sc_ok_i);
    assign next_llbit_value = mem_access_valid & atom_ll_i;

    // Load data is not final until the next stage
    assign fwd_wreg_o  = next_wreg;
    assign fwd_final_o = ~mem_load_i;
    assign fwd_waddr_o = waddr_i;
    assign fwd_wdata_o = next_wdata;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_valid_o       <= 1'b0;
            stage_excp_o        <= 1'b0;
            stage_excp_vec_o    <= '0;
            stage_wreg_o        <= 1'b0;
            stage_waddr_o       <= '0;
            stage_wdata_o       <= '0;
            stage_llbit_we_o    <= 1'b0;
            stage_llbit_value_o <= 1'b0;
            stage_addr_o        <= '0;
            stage_aluop_o       <= '0;
            stage_access_o      <= 1'b0;
        end else if (advance_i) begin
            stage_valid_o       <= instr_valid_i;
            stage_excp_o        <= excp_i;
            stage_excp_vec_o    <= excp_vec_i;
            stage_wreg_o        <= next_wreg;
            stage_waddr_o       <= waddr_i;
            stage_wdata_o       <= next_wdata;
            stage_llbit_we_o    <= next_llbit_we;
            stage_llbit_value_o <= next_llbit_value;
            stage_addr_o        <= paddr_i;
            stage_aluop_o       <= aluop_i;
            stage_access_o      <= mem_access_valid;
        end
    end

endmodule

// File: mem1_settings.svh
`ifndef MEM1_SETTINGS_SVH
`define MEM1_SETTINGS_SVH

// Datapath widths
`define WORD_W      32
`define OP_W        8
`define REG_ADDR_W  5

// Memory operation codes
`define OP_LD_B     8'h20
`define OP_LD_H     8'h21
`define OP_LD_W     8'h22
`define OP_LD_BU    8'h23
`define OP_LD_HU    8'h24
`define OP_ST_B     8'h25
`define OP_ST_H     8'h26
`define OP_ST_W     8'h27

// Atomic pair
`define OP_LL       8'h28
`define OP_SC       8'h29

`endif

// File: mem1_top.f
+incdir+.
mem1_pkg.sv
mem_excp_check.sv
mem_req_encode.sv
mem1_result_merge.sv
mem1_top.sv
tb_mem1_top.sv

// File: mem1_top.sv
module mem1_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid_i,
    input  logic                   excp_in_i,
    input  logic                   mem_load_i,
    input  logic                   mem_store_i,
    input  logic                   trans_en_i,
    input  mem1_pkg::aluop_t       aluop_i,
    input  logic                   wreg_i,
    input  mem1_pkg::reg_addr_t    waddr_i,
    input  mem1_pkg::word_t        wdata_i,
    input  mem1_pkg::word_t        store_data_i,
    input  mem1_pkg::word_t        tlb_paddr_i,
    input  logic                   tlb_found_i,
    input  logic                   tlb_v_i,
    input  logic                   tlb_d_i,
    input  mem1_pkg::plv_t         tlb_plv_i,
    input  mem1_pkg::plv_t         csr_plv_i,
    input  logic                   llbit_i,
    input  logic                   advance_i,
    input  logic                   flush_i,
    input  logic                   dcache_ready_i,
    input  logic                   dcache_ack_i,
    output logic                   dcache_ce_o,
    output logic                   dcache_we_o,
    output mem1_pkg::byte_sel_t    dcache_sel_o,
    output mem1_pkg::word_t        dcache_addr_o,
    output mem1_pkg::word_t        dcache_wdata_o,
    output mem1_pkg::access_type_t dcache_rd_type_o,
    output mem1_pkg::access_type_t dcache_wr_type_o,
    output logic                   advance_ready_o,
    output logic                   fwd_wreg_o,
    output logic                   fwd_final_o,
    output mem1_pkg::reg_addr_t    fwd_waddr_o,
    output mem1_pkg::word_t        fwd_wdata_o,
    output logic                   stage_valid_o,
    output logic                   stage_excp_o,
    output mem1_pkg::excp_vec_t    stage_excp_vec_o,
    output logic                   stage_wreg_o,
    output mem1_pkg::reg_addr_t    stage_waddr_o,
    output mem1_pkg::word_t        stage_wdata_o,
    output logic                   stage_llbit_we_o,
    output logic                   stage_llbit_value_o,
    output mem1_pkg::word_t        stage_addr_o,
    output mem1_pkg::aluop_t       stage_aluop_o,
    output logic                   stage_access_o
);

    import mem1_pkg::*;

    logic         excp;
    excp_vec_t    excp_vec;
    logic         enc_ce;
    logic         enc_we;
    byte_sel_t    enc_sel;
    word_t        enc_wdata;
    access_type_t enc_rd_type;
    access_type_t enc_wr_type;
    logic         atom_ll;
    logic         atom_sc;
    logic         atom_sc_ok;

    mem_excp_check excp_check_i (
        .trans_en_i  (trans_en_i),
        .mem_load_i  (mem_load_i),
        .mem_store_i (mem_store_i),
        .excp_in_i   (excp_in_i),
        .paddr_i     (tlb_paddr_i),
        .tlb_found_i (tlb_found_i),
        .tlb_v_i     (tlb_v_i),
        .tlb_d_i     (tlb_d_i),
        .tlb_plv_i   (tlb_plv_i),
        .csr_plv_i   (csr_plv_i),
        .excp_o      (excp),
        .excp_vec_o  (excp_vec)
    );

    mem_req_encode req_encode_i (
        .aluop_i      (aluop_i),
        .paddr_i      (tlb_paddr_i),
        .store_data_i (store_data_i),
        .llbit_i      (llbit_i),
        .ce_o         (enc_ce),
        .we_o         (enc_we),
        .sel_o        (enc_sel),
        .wdata_o      (enc_wdata),
        .rd_type_o    (enc_rd_type),
        .wr_type_o    (enc_wr_type),
        .ll_o         (atom_ll),
        .sc_o         (atom_sc),
        .sc_ok_o      (atom_sc_ok)
    );

    mem1_result_merge result_merge_i (
        .clk                 (clk),
        .rst                 (rst),
        .flush_i             (flush_i),
        .advance_i           (advance_i),
        .instr_valid_i       (instr_valid_i),
        .mem_load_i          (mem_load_i),
        .mem_store_i         (mem_store_i),
        .excp_i              (excp),
        .excp_vec_i          (excp_vec),
        .wreg_i              (wreg_i),
        .waddr_i             (waddr_i),
        .wdata_i             (wdata_i),
        .paddr_i             (tlb_paddr_i),
        .aluop_i             (aluop_i),
        .enc_ce_i            (enc_ce),
        .enc_we_i            (enc_we),
        .enc_sel_i           (enc_sel),
        .enc_wdata_i         (enc_wdata),
        .enc_rd_type_i       (enc_rd_type),
        .enc_wr_type_i       (enc_wr_type),
        .atom_ll_i           (atom_ll),
        .atom_sc_i           (atom_sc),
        .atom_sc_ok_i        (atom_sc_ok),
        .dcache_ready_i      (dcache_ready_i),
        .dcache_ack_i        (dcache_ack_i),
        .dcache_ce_o         (dcache_ce_o),
        .dcache_we_o         (dcache_we_o),
        .dcache_sel_o        (dcache_sel_o),
        .dcache_addr_o       (dcache_addr_o),
        .dcache_wdata_o      (dcache_wdata_o),
        .dcache_rd_type_o    (dcache_rd_type_o),
        .dcache_wr_type_o    (dcache_wr_type_o),
        .advance_ready_o     (advance_ready_o),
        .fwd_wreg_o          (fwd_wreg_o),
        .fwd_final_o         (fwd_final_o),
        .fwd_waddr_o         (fwd_waddr_o),
        .fwd_wdata_o         (fwd_wdata_o),
        .stage_valid_o       (stage_valid_o),
        .stage_excp_o        (stage_excp_o),
        .stage_excp_vec_o    (stage_excp_vec_o),
        .stage_wreg_o        (stage_wreg_o),
        .stage_waddr_o       (stage_waddr_o),
        .stage_wdata_o       (stage_wdata_o),
        .stage_llbit_we_o    (stage_llbit_we_o),
        .stage_llbit_value_o (stage_llbit_value_o),
        .stage_addr_o        (stage_addr_o),
        .stage_aluop_o       (stage_aluop_o),
        .stage_access_o      (stage_access_o)
    );

endmodule

// File: mem_excp_check.sv
`include "mem1_settings.svh"

module mem_excp_check (
    input  logic                trans_en_i,
    input  logic                mem_load_i,
    input  logic                mem_store_i,
    input  logic                excp_in_i,
    input  mem1_pkg::word_t     paddr_i,
    input  logic                tlb_found_i,
    input  logic                tlb_v_i,
    input  logic                tlb_d_i,
    input  mem1_pkg::plv_t      tlb_plv_i,
    input  mem1_pkg::plv_t      csr_plv_i,
    output logic                excp_o,
    output mem1_pkg::excp_vec_t excp_vec_o
);

    logic access_mem;
    logic plv_ok;
    logic excp_adem;
    logic excp_tlbr;
    logic excp_pil;
    logic excp_pis;
    logic excp_ppi;
    logic excp_pme;

    assign access_mem = mem_load_i | mem_store_i;
    assign plv_ok     = (csr_plv_i <= tlb_plv_i);

    // User mode may not touch the upper half of the address space
    assign excp_adem = trans_en_i & access_mem & (csr_plv_i == 2'd3)
                     & paddr_i[`WORD_W-1];

    assign excp_tlbr = trans_en_i & access_mem & ~tlb_found_i;

    // Invalid page split by access direction
    assign excp_pil = trans_en_i & mem_load_i & ~tlb_v_i;
    assign excp_pis = trans_en_i & mem_store_i & ~tlb_v_i;

    assign excp_ppi = trans_en_i & access_mem & tlb_v_i & ~plv_ok;

    // Store to a clean page
    assign excp_pme = trans_en_i & mem_store_i & tlb_v_i & plv_ok & ~tlb_d_i;

    assign excp_vec_o = {
        excp_pil,
        excp_pis,
        excp_ppi,
        excp_pme,
        excp_tlbr,
        excp_adem
    };

    assign excp_o = excp_in_i | (|excp_vec_o);

endmodule

// File: mem_req_encode.sv
`include "mem1_settings.svh"

module mem_req_encode (
    input  mem1_pkg::aluop_t       aluop_i,
    input  mem1_pkg::word_t        paddr_i,
    input  mem1_pkg::word_t        store_data_i,
    input  logic                   llbit_i,
    output logic                   ce_o,
    output logic                   we_o,
    output mem1_pkg::byte_sel_t    sel_o,
    output mem1_pkg::word_t        wdata_o,
    output mem1_pkg::access_type_t rd_type_o,
    output mem1_pkg::access_type_t wr_type_o,
    output logic                   ll_o,
    output logic                   sc_o,
    output logic                   sc_ok_o
);

    import mem1_pkg::*;

    logic [1:0] lane;
    logic [4:0] bit_shift;
    byte_sel_t  sel_byte;
    byte_sel_t  sel_half;
    word_t      data_byte;
    word_t      data_half;

    assign lane      = paddr_i[1:0];
    assign bit_shift = {lane, 3'b000};

    // Lane aligned enables and store data for sub-word accesses
    assign sel_byte  = byte_sel_t'(4'b0001) << lane;
    assign sel_half  = byte_sel_t'(4'b0011) << lane;
    assign data_byte = {24'b0, store_data_i[7:0]} << bit_shift;
    assign data_half = {16'b0, store_data_i[15:0]} << bit_shift;

    assign ll_o    = (aluop_i == `OP_LL);
    assign sc_o    = (aluop_i == `OP_SC);
    assign sc_ok_o = sc_o & llbit_i;

    always_comb begin
        ce_o      = 1'b0;
        we_o      = 1'b0;
        sel_o     = '0;
        wdata_o   = '0;
        rd_type_o = '0;
        wr_type_o = '0;
        case (aluop_i)
            `OP_LD_B, `OP_LD_BU: begin
                ce_o      = 1'b1;
                sel_o     = sel_byte;
                rd_type_o = 3'd0;
            end
            `OP_LD_H, `OP_LD_HU: begin
                ce_o      = 1'b1;
                sel_o     = sel_half;
                rd_type_o = 3'd1;
            end
            `OP_LD_W, `OP_LL: begin
                ce_o      = 1'b1;
                sel_o     = '1;
                rd_type_o = 3'd2;
            end
            `OP_ST_B: begin
                ce_o      = 1'b1;
                we_o      = 1'b1;
                sel_o     = sel_byte;
                wdata_o   = data_byte;
                wr_type_o = 3'd0;
            end
            `OP_ST_H: begin
                ce_o      = 1'b1;
                we_o      = 1'b1;
                sel_o     = sel_half;
                wdata_o   = data_half;
                wr_type_o = 3'd1;
            end
            `OP_ST_W: begin
                ce_o      = 1'b1;
                we_o      = 1'b1;
                sel_o     = '1;
                wdata_o   = store_data_i;
                wr_type_o = 3'd2;
            end
            `OP_SC: begin
                // Failed SC leaves the cache alone
                if (llbit_i) begin
                    ce_o      = 1'b1;
                    we_o      = 1'b1;
                    sel_o     = '1;
                    wdata_o   = store_data_i;
                    wr_type_o = 3'd2;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the mem1 testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_mem1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mem1_top -f mem1_top.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_mem1_top.sv
`include "mem1_settings.svh"

module tb_mem1_top;

    timeunit 1ns;
    timeprecision 100ps;

    import mem1_pkg::*;

    localparam int RESET_CYCLES   = 3;
    localparam int RANDOM_CYCLES  = 357;
    localparam int LLSC_CYCLES    = 40;
    localparam int RUN_CYCLES     = RESET_CYCLES + RANDOM_CYCLES + LLSC_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES + 200;

    typedef enum logic [1:0] {PH_RESET, PH_RANDOM, PH_LLSC, PH_DONE} phase_t;

    typedef struct packed {
        logic      valid;
        logic      excp;
        excp_vec_t excp_vec;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        logic      llbit_we;
        logic      llbit_value;
        word_t     addr;
        aluop_t    aluop;
        logic      access;
    } stage_t;

    logic         clk;
    logic         rst;
    logic         instr_valid_i, excp_in_i, mem_load_i, mem_store_i, trans_en_i;
    aluop_t       aluop_i;
    logic         wreg_i;
    reg_addr_t    waddr_i;
    word_t        wdata_i, store_data_i, tlb_paddr_i;
    logic         tlb_found_i, tlb_v_i, tlb_d_i, llbit_i;
    plv_t         tlb_plv_i, csr_plv_i;
    logic         advance_i, flush_i, dcache_ready_i, dcache_ack_i;
    logic         dcache_ce_o, dcache_we_o, advance_ready_o, fwd_wreg_o, fwd_final_o;
    byte_sel_t    dcache_sel_o;
    word_t        dcache_addr_o, dcache_wdata_o, fwd_wdata_o;
    access_type_t dcache_rd_type_o, dcache_wr_type_o;
    reg_addr_t    fwd_waddr_o, stage_waddr_o;
    logic         stage_valid_o, stage_excp_o, stage_wreg_o, stage_access_o;
    logic         stage_llbit_we_o, stage_llbit_value_o;
    excp_vec_t    stage_excp_vec_o;
    word_t        stage_wdata_o, stage_addr_o;
    aluop_t       stage_aluop_o;

    // Reference model results
    excp_vec_t    e_excp_vec;
    logic         e_excp, e_access, e_send, e_we, e_adv_ready;
    byte_sel_t    e_sel;
    word_t        e_addr, e_wdata;
    access_type_t e_rd_type, e_wr_type;
    stage_t       e_next;
    stage_t       m_stage;

    phase_t phase;
    int     seed = 64;
    int     error_count = 0;
    int     cycle_count;
    int     llsc_step;

    mem1_top dut_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic op_is_load(input aluop_t op);
        return op inside {`OP_LD_B, `OP_LD_BU, `OP_LD_H, `OP_LD_HU, `OP_LD_W, `OP_LL};
    endfunction

    function automatic logic op_is_store(input aluop_t op);
        return op inside {`OP_ST_B, `OP_ST_H, `OP_ST_W, `OP_SC};
    endfunction

    function automatic access_type_t op_size(input aluop_t op);
        if (op inside {`OP_LD_B, `OP_LD_BU, `OP_ST_B}) begin
            return 3'd0;
        end
        if (op inside {`OP_LD_H, `OP_LD_HU, `OP_ST_H}) begin
            return 3'd1;
        end
        return 3'd2;
    endfunction

    function automatic aluop_t op_at(input int idx);
        case (idx)
            0: return `OP_LD_B;
            1: return `OP_LD_BU;
            2: return `OP_LD_H;
            3: return `OP_LD_HU;
            4: return `OP_LD_W;
            5: return `OP_ST_B;
            6: return `OP_ST_H;
            7: return `OP_ST_W;
            8: return `OP_LL;
            9: return `OP_SC;
            default: return 8'h05;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        error_count++;
        $display("Fail %s exp %h got %h", name, exp_val, got_val);
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    always_comb begin : ref_model
        logic         is_ld;
        logic         is_st;
        logic         plv_fail;
        logic         touches_mem;
        logic         sc_done;
        access_type_t size;
        logic [1:0]   shift;
        byte_sel_t    base_sel;
        word_t        data_mask;

        is_ld       = op_is_load(aluop_i);
        is_st       = op_is_store(aluop_i);
        touches_mem = mem_load_i | mem_store_i;
        plv_fail    = csr_plv_i > tlb_plv_i;

        e_excp_vec[5] = trans_en_i & mem_load_i & ~tlb_v_i;
        e_excp_vec[4] = trans_en_i & mem_store_i & ~tlb_v_i;
        e_excp_vec[3] = trans_en_i & touches_mem & tlb_v_i & plv_fail;
        e_excp_vec[2] = trans_en_i & mem_store_i & tlb_v_i & ~plv_fail & ~tlb_d_i;
        e_excp_vec[1] = trans_en_i & touches_mem & ~tlb_found_i;
        e_excp_vec[0] = trans_en_i & touches_mem & (csr_plv_i == 2'd3)
                      & tlb_paddr_i[`WORD_W-1];
        e_excp   = excp_in_i | (|e_excp_vec);
        e_access = instr_valid_i & ~e_excp;

        // SC only reaches the cache while the LL bit is set
        e_send = e_access & dcache_ready_i
               & (is_ld | (is_st & ((aluop_i != `OP_SC) | llbit_i)));

        size  = op_size(aluop_i);
        shift = (size == 3'd2) ? 2'd0 : tlb_paddr_i[1:0];
        case (size)
            3'd0: begin
                base_sel  = 4'b0001;
                data_mask = 32'h0000_00ff;
            end
            3'd1: begin
                base_sel  = 4'b0011;
                data_mask = 32'h0000_ffff;
            end
            default: begin
                base_sel  = 4'b1111;
                data_mask = 32'hffff_ffff;
            end
        endcase

        e_we        = e_send & is_st;
        e_sel       = e_send ? byte_sel_t'(base_sel << shift) : '0;
        e_addr      = e_send ? tlb_paddr_i : '0;
        e_wdata     = e_we ? (store_data_i & data_mask) << {shift, 3'b000} : '0;
        e_rd_type   = (e_send & is_ld) ? size : '0;
        e_wr_type   = e_we ? size : '0;
        e_adv_ready = ~(e_access & touches_mem & ~dcache_ack_i);

        sc_done = e_access & (aluop_i == `OP_SC);
        e_next.valid       = instr_valid_i;
        e_next.excp        = e_excp;
        e_next.excp_vec    = e_excp_vec;
        e_next.wreg        = wreg_i | sc_done;
        e_next.waddr       = waddr_i;
        e_next.wdata       = sc_done ? {31'b0, llbit_i} : wdata_i;
        e_next.llbit_we    = e_access & ((aluop_i == `OP_LL) | ((aluop_i == `OP_SC) & llbit_i));
        e_next.llbit_value = e_access & (aluop_i == `OP_LL);
        e_next.addr        = tlb_paddr_i;
        e_next.aluop       = aluop_i;
        e_next.access      = e_access;
    end

    // Stage register model where flush wins over advance
    always @(posedge clk) begin
        if (rst || flush_i) begin
            m_stage <= '0;
        end else if (advance_i) begin
            m_stage <= e_next;
        end
    end

    // Checks sample at the falling edge where inputs and outputs are settled
    assert property (@(negedge clk) disable iff (rst) dcache_ce_o == e_send)
        else report_mismatch("dcache_ce_o", 32'(e_send), 32'(dcache_ce_o));
    assert property (@(negedge clk) disable iff (rst) dcache_we_o == e_we)
        else report_mismatch("dcache_we_o", 32'(e_we), 32'(dcache_we_o));
    assert property (@(negedge clk) disable iff (rst) dcache_sel_o == e_sel)
        else report_mismatch("dcache_sel_o", 32'(e_sel), 32'(dcache_sel_o));
    assert property (@(negedge clk) disable iff (rst) dcache_addr_o == e_addr)
        else report_mismatch("dcache_addr_o", e_addr, dcache_addr_o);
    assert property (@(negedge clk) disable iff (rst) dcache_wdata_o == e_wdata)
        else report_mismatch("dcache_wdata_o", e_wdata, dcache_wdata_o);
    assert property (@(negedge clk) disable iff (rst) dcache_rd_type_o == e_rd_type)
        else report_mismatch("dcache_rd_type_o", 32'(e_rd_type), 32'(dcache_rd_type_o));
    assert property (@(negedge clk) disable iff (rst) dcache_wr_type_o == e_wr_type)
        else report_mismatch("dcache_wr_type_o", 32'(e_wr_type), 32'(dcache_wr_type_o));
    assert property (@(negedge clk) disable iff (rst) advance_ready_o == e_adv_ready)
        else report_mismatch("advance_ready_o", 32'(e_adv_ready), 32'(advance_ready_o));
    assert property (@(negedge clk) disable iff (rst) fwd_wreg_o == e_next.wreg)
        else report_mismatch("fwd_wreg_o", 32'(e_next.wreg), 32'(fwd_wreg_o));
    assert property (@(negedge clk) disable iff (rst) fwd_final_o == !op_is_load(aluop_i))
        else report_mismatch("fwd_final_o", 32'(!op_is_load(aluop_i)), 32'(fwd_final_o));
    assert property (@(negedge clk) disable iff (rst) fwd_waddr_o == waddr_i)
        else report_mismatch("fwd_waddr_o", 32'(waddr_i), 32'(fwd_waddr_o));
    assert property (@(negedge clk) disable iff (rst) fwd_wdata_o == e_next.wdata)
        else report_mismatch("fwd_wdata_o", e_next.wdata, fwd_wdata_o);
    assert property (@(negedge clk) disable iff (rst) e_excp |-> !dcache_ce_o && advance_ready_o)
        else note_failure("Exception did not block the cache request or stalled the stage");
    assert property (@(negedge clk) disable iff (rst)
        (e_access && aluop_i == `OP_SC && !llbit_i) |-> !dcache_ce_o && fwd_wdata_o == '0)
        else note_failure("SC without the LL bit issued a request or reported success");

    assert property (@(negedge clk) disable iff (rst) stage_valid_o == m_stage.valid)
        else report_mismatch("stage_valid_o", 32'(m_stage.valid), 32'(stage_valid_o));
    assert property (@(negedge clk) disable iff (rst) stage_excp_o == m_stage.excp)
        else report_mismatch("stage_excp_o", 32'(m_stage.excp), 32'(stage_excp_o));
    assert property (@(negedge clk) disable iff (rst) stage_excp_vec_o == m_stage.excp_vec)
        else report_mismatch("stage_excp_vec_o", 32'(m_stage.excp_vec), 32'(stage_excp_vec_o));
    assert property (@(negedge clk) disable iff (rst) stage_wreg_o == m_stage.wreg)
        else report_mismatch("stage_wreg_o", 32'(m_stage.wreg), 32'(stage_wreg_o));
    assert property (@(negedge clk) disable iff (rst) stage_waddr_o == m_stage.waddr)
        else report_mismatch("stage_waddr_o", 32'(m_stage.waddr), 32'(stage_waddr_o));
    assert property (@(negedge clk) disable iff (rst) stage_wdata_o == m_stage.wdata)
        else report_mismatch("stage_wdata_o", m_stage.wdata, stage_wdata_o);
    assert property (@(negedge clk) disable iff (rst) stage_llbit_we_o == m_stage.llbit_we)
        else report_mismatch("stage_llbit_we_o", 32'(m_stage.llbit_we), 32'(stage_llbit_we_o));
    assert property (@(negedge clk) disable iff (rst)
        stage_llbit_value_o == m_stage.llbit_value)
        else report_mismatch("stage_llbit_value_o", 32'(m_stage.llbit_value),
                             32'(stage_llbit_value_o));
    assert property (@(negedge clk) disable iff (rst) stage_addr_o == m_stage.addr)
        else report_mismatch("stage_addr_o", m_stage.addr, stage_addr_o);
    assert property (@(negedge clk) disable iff (rst) stage_aluop_o == m_stage.aluop)
        else report_mismatch("stage_aluop_o", 32'(m_stage.aluop), 32'(stage_aluop_o));
    assert property (@(negedge clk) disable iff (rst) stage_access_o == m_stage.access)
        else report_mismatch("stage_access_o", 32'(m_stage.access), 32'(stage_access_o));

    task automatic drive_idle();
        instr_valid_i <= 1'b0;
        advance_i     <= 1'b0;
        flush_i       <= 1'b0;
    endtask

    task automatic drive_random_cycle();
        logic [31:0] r;
        logic [31:0] r2;
        aluop_t      op;

        r  = $random(seed);
        r2 = $random(seed);
        op = op_at($unsigned($random(seed)) % 11);
        aluop_i        <= op;
        mem_load_i     <= op_is_load(op);
        mem_store_i    <= op_is_store(op);
        instr_valid_i  <= |r[2:0];
        excp_in_i      <= ~|r[7:3];
        trans_en_i     <= |r[9:8];
        tlb_found_i    <= |r[12:10];
        tlb_v_i        <= |r[15:13];
        tlb_d_i        <= r[16];
        tlb_plv_i      <= r[18:17];
        csr_plv_i      <= r[20:19];
        llbit_i        <= r[21];
        dcache_ready_i <= |r[23:22];
        dcache_ack_i   <= r[24];
        flush_i        <= ~|r[29:25];
        advance_i      <= |r[31:30];
        wreg_i         <= r2[5];
        waddr_i        <= r2[4:0];
        tlb_paddr_i    <= $random(seed);
        wdata_i        <= $random(seed);
        store_data_i   <= $random(seed);
    endtask

    // LL and two SC attempts followed by loads and stores at a lane that steps every 8 ops
    task automatic drive_directed_cycle();
        aluop_t op;

        case (llsc_step % 8)
            0: op = `OP_LL;
            1: op = `OP_SC;
            2: op = `OP_SC;
            3: op = `OP_ST_B;
            4: op = `OP_ST_H;
            5: op = `OP_LD_B;
            6: op = `OP_LD_HU;
            default: op = `OP_ST_W;
        endcase
        aluop_i        <= op;
        mem_load_i     <= op_is_load(op);
        mem_store_i    <= op_is_store(op);
        instr_valid_i  <= 1'b1;
        excp_in_i      <= 1'b0;
        trans_en_i     <= 1'b1;
        tlb_found_i    <= 1'b1;
        tlb_v_i        <= 1'b1;
        tlb_d_i        <= 1'b1;
        tlb_plv_i      <= 2'd3;
        csr_plv_i      <= 2'd0;
        llbit_i        <= (llsc_step % 8) != 2;
        dcache_ready_i <= 1'b1;
        dcache_ack_i   <= 1'b1;
        advance_i      <= 1'b1;
        flush_i        <= 1'b0;
        wreg_i         <= 1'b0;
        waddr_i        <= 5'(llsc_step);
        wdata_i        <= 32'h5a5a_0000 + llsc_step;
        tlb_paddr_i    <= {28'h1000004, 2'b00, llsc_step[4:3]};
        store_data_i   <= $random(seed);
        llsc_step = llsc_step + 1;
    endtask

    always @(posedge clk) begin
        case (phase)
            PH_RANDOM: drive_random_cycle();
            PH_LLSC:   drive_directed_cycle();
            default:   drive_idle();
        endcase
    end

    initial begin
        phase          = PH_RESET;
        llsc_step      = 0;
        rst            = 1'b1;
        instr_valid_i  = 1'b0;
        excp_in_i      = 1'b0;
        mem_load_i     = 1'b0;
        mem_store_i    = 1'b0;
        trans_en_i     = 1'b0;
        aluop_i        = '0;
        wreg_i         = 1'b0;
        waddr_i        = '0;
        wdata_i        = '0;
        store_data_i   = '0;
        tlb_paddr_i    = '0;
        tlb_found_i    = 1'b0;
        tlb_v_i        = 1'b0;
        tlb_d_i        = 1'b0;
        tlb_plv_i      = '0;
        csr_plv_i      = '0;
        llbit_i        = 1'b0;
        advance_i      = 1'b0;
        flush_i        = 1'b0;
        dcache_ready_i = 1'b0;
        dcache_ack_i   = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!stage_valid_o && !stage_wreg_o && !stage_llbit_we_o && !dcache_ce_o)
            else note_failure("Stage outputs or cache request not idle after reset");

        phase = PH_RANDOM;
        repeat (RANDOM_CYCLES) @(posedge clk);
        @(negedge clk);
        phase = PH_LLSC;
        repeat (LLSC_CYCLES) @(posedge clk);
        @(negedge clk);
        phase = PH_DONE;
        repeat (2) @(negedge clk);

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without reaching the end", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
